// File: source/sprite_pkg.sv
package sprite_pkg;

    // --------------------------------------------------
    // Frame and sprite geometry
    // --------------------------------------------------
    localparam int FRAME_W     = 32;
    localparam int FRAME_H     = 24;
    localparam int NUM_SPRITES = 8;
    localparam int MAX_LAYERS  = 4;
    localparam int SPRITE_SIZE = 8;
    localparam int NUM_IMAGES  = 4;

    // Derived widths
    localparam int X_W     = 10;
    localparam int Y_W     = 9;
    localparam int OFS_W   = $clog2(SPRITE_SIZE);
    localparam int IMG_W   = $clog2(NUM_IMAGES);
    localparam int SLOT_W  = $clog2(NUM_SPRITES);
    localparam int LAYER_W = $clog2(MAX_LAYERS);

    // Register port
    localparam int REG_AW = 8;
    localparam int REG_DW = 32;

    // Sprite ROM, one image after the other
    localparam int ROM_DEPTH = NUM_IMAGES * SPRITE_SIZE * SPRITE_SIZE;
    localparam int ROM_AW    = $clog2(ROM_DEPTH);

    // Magenta colour key
    localparam logic [23:0] TRANSPARENT = 24'hFF_00_FF;

    // --------------------------------------------------
    // Shared types
    // --------------------------------------------------
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic             enable;
        logic [X_W-1:0]   x;
        logic [Y_W-1:0]   y;
        logic [IMG_W-1:0] image;
    } sprite_attr_t;

    typedef struct packed {
        logic             valid;
        logic [IMG_W-1:0] image;
        logic [OFS_W-1:0] row;
        logic [OFS_W-1:0] col;
    } layer_hit_t;

    // Image content, addressed as {image, row, col}
    // Every third diagonal is see-through
    function automatic rgb_t sprite_pattern(input logic [ROM_AW-1:0] addr);
        logic [IMG_W-1:0] image;
        logic [OFS_W-1:0] row;
        logic [OFS_W-1:0] col;
        int               sum;
        rgb_t             px;
        {image, row, col} = addr;
        sum = int'(image) + int'(row) + int'(col);
        if (sum % 3 == 0) begin
            px = TRANSPARENT;
        end else begin
            // Green never reaches zero, so no clash with the key
            px.r = 8'(row * 32 + 31);
            px.g = 8'(col * 32 + 16);
            px.b = 8'(image * 64 + sum * 4);
        end
        return px;
    endfunction

endpackage

// File: source/pixel_counter.sv
module pixel_counter
    import sprite_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pc_enable,
    output logic [X_W-1:0] pixel_x,
    output logic [Y_W-1:0] pixel_y,
    output logic           frame_wrap
);

    logic last_x;
    logic last_y;

    assign last_x = (pixel_x == X_W'(FRAME_W - 1));
    assign last_y = (pixel_y == Y_W'(FRAME_H - 1));

    // High in the cycle that moves the last pixel back to the origin
    assign frame_wrap = pc_enable && last_x && last_y;

    // Raster order, x first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_x <= '0;
            pixel_y <= '0;
        end else if (pc_enable) begin
            if (last_x) begin
                pixel_x <= '0;
                pixel_y <= last_y ? '0 : pixel_y + 1'b1;
            end else begin
                pixel_x <= pixel_x + 1'b1;
            end
        end
    end

endmodule

// File: source/sprite_table.sv
module sprite_table
    import sprite_pkg::*;
(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          avalon_write,
    input  logic [REG_AW-1:0]             avalon_address,
    input  logic [REG_DW-1:0]             avalon_writedata,
    input  logic                          frame_wrap,
    input  logic [X_W-1:0]                pixel_x,
    input  logic [Y_W-1:0]                pixel_y,
    output logic [NUM_SPRITES-1:0]        visible,
    output layer_hit_t [NUM_SPRITES-1:0]  hits
);

    sprite_attr_t shadow [NUM_SPRITES];
    sprite_attr_t active [NUM_SPRITES];
    sprite_attr_t wr_attr;
    logic         wr_hit;

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    always_comb begin
        wr_attr.enable = avalon_writedata[31];
        wr_attr.x      = avalon_writedata[28:19];
        wr_attr.y      = avalon_writedata[17:9];
        wr_attr.image  = avalon_writedata[1:0];
    end

    // Addresses past the last slot are ignored
    assign wr_hit = avalon_write && (avalon_address < REG_AW'(NUM_SPRITES));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow <= '{default: '0};
            active <= '{default: '0};
        end else begin
            if (wr_hit) begin
                shadow[avalon_address[SLOT_W-1:0]] <= wr_attr;
            end
            // New attributes only at frame start
            if (frame_wrap) begin
                active <= shadow;
            end
        end
    end

    // --------------------------------------------------
    // Per-sprite hit test
    // --------------------------------------------------
    for (genvar i = 0; i < NUM_SPRITES; i++) begin : g_hit
        logic [X_W:0] dx;
        logic [Y_W:0] dy;

        // Left of or above the sprite wraps to a large offset
        assign dx = {1'b0, pixel_x} - {1'b0, active[i].x};
        assign dy = {1'b0, pixel_y} - {1'b0, active[i].y};

        assign visible[i] = active[i].enable
                         && (dx < (X_W + 1)'(SPRITE_SIZE))
                         && (dy < (Y_W + 1)'(SPRITE_SIZE));

        assign hits[i].valid = visible[i];
        assign hits[i].image = active[i].image;
        assign hits[i].row   = dy[OFS_W-1:0];
        assign hits[i].col   = dx[OFS_W-1:0];
    end

endmodule

// File: source/sprite_selector.sv
module sprite_selector
    import sprite_pkg::*;
(
    input  logic [NUM_SPRITES-1:0]       visible,
    input  layer_hit_t [NUM_SPRITES-1:0] hits,
    output layer_hit_t [MAX_LAYERS-1:0]  layers
);

    // Lowest slot ends up in layer 0, the front layer
    always_comb begin
        logic [LAYER_W:0] n;
        n = '0;
        layers = '0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            if (visible[s] && (n < (LAYER_W + 1)'(MAX_LAYERS))) begin
                layers[n[LAYER_W-1:0]]       = hits[s];
                layers[n[LAYER_W-1:0]].valid = 1'b1;
                n = n + 1'b1;
            end
        end
    end

endmodule

// File: source/rom_sprites.sv
module rom_sprites
    import sprite_pkg::*;
(
    input  logic              clk,
    input  logic [ROM_AW-1:0] rom_addr,
    output rgb_t              rom_data
);

    rgb_t mem [ROM_DEPTH];

    // Contents come from the shared pattern function
    initial begin
        for (int a = 0; a < ROM_DEPTH; a++) begin
            mem[a] = sprite_pattern(ROM_AW'(a));
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rom_data <= mem[rom_addr];
    end

endmodule

// File: source/layer_fetcher.sv
module layer_fetcher
    import sprite_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_fetch,
    input  layer_hit_t [MAX_LAYERS-1:0] layers,
    input  rgb_t                        bg_q,
    input  rgb_t                        rom_data,
    output logic [ROM_AW-1:0]           rom_addr,
    output rgb_t                        pixel_out,
    output logic                        done
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA
    } fetch_state_t;

    fetch_state_t                state;
    layer_hit_t [MAX_LAYERS-1:0] layers_q;
    rgb_t                        bg_r;
    logic [LAYER_W:0]            idx;
    layer_hit_t                  cur;
    logic                        more;
    logic                        opaque;

    // Valid layers are packed at the front, so the first gap ends the scan
    assign cur    = layers_q[idx[LAYER_W-1:0]];
    assign more   = (idx < (LAYER_W + 1)'(MAX_LAYERS)) && cur.valid;
    assign opaque = (rom_data != TRANSPARENT);

    assign rom_addr = {cur.image, cur.row, cur.col};

    // --------------------------------------------------
    // Scan sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (start_fetch) begin
                        idx   <= '0;
                        state <= F_ADDR;
                    end
                end
                // Address goes out this cycle
                F_ADDR: begin
                    if (more) begin
                        state <= F_DATA;
                    end else begin
                        done  <= 1'b1;
                        state <= F_IDLE;
                    end
                end
                // ROM data is back
                F_DATA: begin
                    if (opaque) begin
                        done  <= 1'b1;
                        state <= F_IDLE;
                    end else begin
                        idx   <= idx + 1'b1;
                        state <= F_ADDR;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    // Latched inputs and result
    always_ff @(posedge clk) begin
        if (state == F_IDLE && start_fetch) begin
            layers_q <= layers;
            bg_r     <= bg_q;
        end
        if (state == F_ADDR && !more) begin
            pixel_out <= bg_r;
        end else if (state == F_DATA && opaque) begin
            pixel_out <= rom_data;
        end
    end

endmodule

// File: source/composer_ctrl.sv
module composer_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic bg_empty,
    input  logic done,
    input  logic wrfull,
    output logic start_fetch,
    output logic bg_rdreq,
    output logic pc_enable,
    output logic wrreq
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WRITE
    } ctrl_state_t;

    ctrl_state_t state;

    // --------------------------------------------------
    // Strobes, decoded from the current state
    // --------------------------------------------------
    assign start_fetch = (state == IDLE) && !bg_empty;

    // Write, pop and advance happen on the same edge
    assign wrreq     = (state == WRITE) && !wrfull;
    assign bg_rdreq  = wrreq;
    assign pc_enable = wrreq;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (!bg_empty) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (done) begin
                        state <= WRITE;
                    end
                end
                // Hold while the output FIFO is full
                WRITE: begin
                    if (!wrfull) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: source/composer.sv
module composer
    import sprite_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // Sprite register port
    input  logic              avalon_write,
    input  logic [REG_AW-1:0] avalon_address,
    input  logic [REG_DW-1:0] avalon_writedata,

    // Background FIFO, show-ahead
    input  rgb_t              bg_q,
    input  logic              bg_empty,
    output logic              bg_rdreq,

    // Output FIFO
    input  logic              wrfull,
    output logic              wrreq,
    output rgb_t              pixel_out
);

    logic [X_W-1:0]              pixel_x;
    logic [Y_W-1:0]              pixel_y;
    logic                        frame_wrap;
    logic                        pc_enable;
    logic [NUM_SPRITES-1:0]      visible;
    layer_hit_t [NUM_SPRITES-1:0] hits;
    layer_hit_t [MAX_LAYERS-1:0] layers;
    logic [ROM_AW-1:0]           rom_addr;
    rgb_t                        rom_data;
    logic                        start_fetch;
    logic                        done;

    // --------------------------------------------------
    // Position and sprite attributes
    // --------------------------------------------------
    pixel_counter u_pixel_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_enable  (pc_enable),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .frame_wrap (frame_wrap)
    );

    sprite_table u_sprite_table (
        .clk              (clk),
        .rst_n            (rst_n),
        .avalon_write     (avalon_write),
        .avalon_address   (avalon_address),
        .avalon_writedata (avalon_writedata),
        .frame_wrap       (frame_wrap),
        .pixel_x          (pixel_x),
        .pixel_y          (pixel_y),
        .visible          (visible),
        .hits             (hits)
    );

    sprite_selector u_sprite_selector (
        .visible (visible),
        .hits    (hits),
        .layers  (layers)
    );

    // --------------------------------------------------
    // Pixel fetch and output sequencing
    // --------------------------------------------------
    rom_sprites u_rom_sprites (
        .clk      (clk),
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    layer_fetcher u_layer_fetcher (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_fetch (start_fetch),
        .layers      (layers),
        .bg_q        (bg_q),
        .rom_data    (rom_data),
        .rom_addr    (rom_addr),
        .pixel_out   (pixel_out),
        .done        (done)
    );

    composer_ctrl u_composer_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .bg_empty    (bg_empty),
        .done        (done),
        .wrfull      (wrfull),
        .start_fetch (start_fetch),
        .bg_rdreq    (bg_rdreq),
        .pc_enable   (pc_enable),
        .wrreq       (wrreq)
    );

endmodule

// File: sim/composer_tb.sv
module composer_tb
    import sprite_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_PIXELS = FRAME_W * FRAME_H;

    logic              clk;
    logic              rst_n;
    logic              avalon_write;
    logic [REG_AW-1:0] avalon_address;
    logic [REG_DW-1:0] avalon_writedata;
    rgb_t              bg_q;
    logic              bg_empty;
    logic              bg_rdreq;
    logic              wrfull;
    logic              wrreq;
    rgb_t              pixel_out;

    // Background FIFO contents with the front shown on bg_q
    rgb_t         bg_fifo[$];
    logic         hold_bg;
    int           full_pct;
    int           empty_pct;

    // Reference model state
    sprite_attr_t sh_model [NUM_SPRITES];
    sprite_attr_t act_model [NUM_SPRITES];
    int           mx;
    int           my;

    int           out_count;
    int           pop_count;
    int           push_count;
    int           errors;
    int           tests;
    int           test_errors;
    logic         timed_out;
    string        cur_test;

    composer u_composer (
        .clk              (clk),
        .rst_n            (rst_n),
        .avalon_write     (avalon_write),
        .avalon_address   (avalon_address),
        .avalon_writedata (avalon_writedata),
        .bg_q             (bg_q),
        .bg_empty         (bg_empty),
        .bg_rdreq         (bg_rdreq),
        .wrfull           (wrfull),
        .wrreq            (wrreq),
        .pixel_out        (pixel_out)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %06h, actual %06h", name, expected, actual);
        end
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic sprite_attr_t decode_attr(input logic [31:0] d);
        sprite_attr_t a;
        a.enable = d[31];
        a.x      = d[28:19];
        a.y      = d[17:9];
        a.image  = d[1:0];
        return a;
    endfunction

    // Unused register bits carry random junk
    function automatic logic [31:0] make_word(input logic en, input int x, input int y,
                                              input int img);
        logic [31:0] w;
        w        = $urandom;
        w[31]    = en;
        w[28:19] = 10'(x);
        w[17:9]  = 9'(y);
        w[1:0]   = 2'(img);
        return w;
    endfunction

    // Frontmost opaque pixel among the first MAX_LAYERS visible slots
    function automatic rgb_t expected_pixel(input rgb_t bg);
        int used;
        int dx;
        int dy;
        int img;
        used = 0;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            dx  = mx - int'(act_model[s].x);
            dy  = my - int'(act_model[s].y);
            img = int'(act_model[s].image);
            if (act_model[s].enable && dx >= 0 && dx < SPRITE_SIZE && dy >= 0
                && dy < SPRITE_SIZE && used < MAX_LAYERS) begin
                used++;
                if ((img + dx + dy) % 3 != 0) begin
                    return sprite_pattern(ROM_AW'(img * 64 + dy * 8 + dx));
                end
            end
        end
        return bg;
    endfunction

    function automatic void advance_position();
        mx++;
        if (mx == FRAME_W) begin
            mx = 0;
            my++;
            if (my == FRAME_H) begin
                my = 0;
                act_model = sh_model;
            end
        end
    endfunction

    // Wrap copies the old shadow, so the write lands after it
    always @(posedge clk) begin
        if (rst_n) begin
            if (wrreq) begin
                if (bg_fifo.size() == 0) begin
                    errors++;
                    $display("Output pixel written with no background pixel available");
                end else begin
                    check_value(cur_test, expected_pixel(bg_fifo[0]), pixel_out);
                end
                out_count++;
                advance_position();
            end
            if (bg_rdreq) begin
                pop_count++;
                if (bg_fifo.size() > 0) begin
                    void'(bg_fifo.pop_front());
                end
            end
            if (avalon_write && avalon_address < NUM_SPRITES) begin
                sh_model[avalon_address] = decode_attr(avalon_writedata);
            end
        end
    end

    // --------------------------------------------------
    // FIFO side stimulus, falling edge
    // --------------------------------------------------
    always @(negedge clk) begin
        logic pause;
        pause = 1'b0;
        if (rst_n) begin
            wrfull <= ($urandom_range(99) < full_pct);
            pause  = ($urandom_range(99) < empty_pct);
        end
        bg_empty <= (bg_fifo.size() == 0) || hold_bg || pause;
        bg_q     <= (bg_fifo.size() > 0) ? bg_fifo[0] : '0;
    end

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        avalon_write     = 1'b1;
        avalon_address   = addr;
        avalon_writedata = data;
        @(negedge clk);
        avalon_write     = 1'b0;
    endtask

    task automatic run_pixels(input int n);
        int target;
        int cycles;
        if (timed_out) begin
            return;
        end
        target = out_count + n;
        for (int i = 0; i < n; i++) begin
            bg_fifo.push_back(rgb_t'(24'($urandom)));
            push_count++;
        end
        cycles = 0;
        while (out_count < target && cycles < n * 100 + 1000) begin
            @(negedge clk);
            cycles++;
        end
        if (out_count < target) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout in %s: only %0d of %0d pixels were written",
                     cur_test, n - (target - out_count), n);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = errors;
        tests++;
    endtask

    task automatic finish_test();
        $display("%s finished with %0d errors", cur_test, errors - test_errors);
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic run_random_sprites();
        int x;
        int y;
        hold_bg = 1'b1;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            x = ($urandom_range(7) == 0) ? 1000 : $urandom_range(FRAME_W + 4);
            y = $urandom_range(FRAME_H + 4);
            write_reg(8'(s), make_word($urandom_range(3) != 0, x, y, $urandom_range(3)));
        end
        hold_bg = 1'b0;
        run_pixels(2 * FRAME_PIXELS);
    endtask

    // Front four layers go see-through together where slot 4 is opaque
    task automatic run_stacked_sprites();
        hold_bg = 1'b1;
        for (int s = 0; s < NUM_SPRITES; s++) begin
            write_reg(8'(s), make_word(1'b1, 12 + s % 2, 9, (s < MAX_LAYERS) ? s % 2 : 2));
        end
        hold_bg = 1'b0;
        run_pixels(2 * FRAME_PIXELS);
    endtask

    task automatic run_mid_frame_update();
        run_pixels(FRAME_PIXELS / 2);
        hold_bg = 1'b1;
        write_reg(8'd1, make_word(1'b1, 3, 3, 1));
        write_reg(8'd1, make_word(1'b1, 20, 14, 2));
        write_reg(8'd0, make_word(1'b0, 0, 0, 0));
        write_reg(8'(NUM_SPRITES + $urandom_range(7)), make_word(1'b1, 0, 0, 3));
        write_reg(8'd200, make_word(1'b1, 5, 5, 0));
        hold_bg = 1'b0;
        run_pixels(FRAME_PIXELS + FRAME_PIXELS / 2);
    endtask

    task automatic report_and_finish();
        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(52));
        clk              = 1'b0;
        rst_n            = 1'b0;
        avalon_write     = 1'b0;
        avalon_address   = '0;
        avalon_writedata = '0;
        bg_q             = '0;
        bg_empty         = 1'b1;
        wrfull           = 1'b0;
        hold_bg          = 1'b0;
        full_pct         = 20;
        empty_pct        = 20;
        sh_model         = '{default: '0};
        act_model        = '{default: '0};
        mx               = 0;
        my               = 0;
        out_count        = 0;
        pop_count        = 0;
        push_count       = 0;
        errors           = 0;
        tests            = 0;
        timed_out        = 1'b0;
        cur_test         = "reset";

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        start_test("background_only");
        run_pixels(FRAME_PIXELS);
        finish_test();

        start_test("random_sprites");
        run_random_sprites();
        finish_test();

        start_test("layer_limit");
        run_stacked_sprites();
        finish_test();

        start_test("mid_frame_update");
        run_mid_frame_update();
        finish_test();

        // Heavy stalls on both FIFOs
        start_test("stall_stress");
        full_pct  = 50;
        empty_pct = 50;
        run_pixels(FRAME_PIXELS);
        check_value(cur_test, push_count, pop_count);
        finish_test();

        report_and_finish();
    end

endmodule

// File: tb.f
source/sprite_pkg.sv
source/pixel_counter.sv
source/sprite_table.sv
source/sprite_selector.sv
source/rom_sprites.sv
source/layer_fetcher.sv
source/composer_ctrl.sv
source/composer.sv
sim/composer_tb.sv
